//--- sources.f
mem_pkg.sv
mem_req_if.sv
mem_rsp_if.sv
rep_sequencer.sv
dcache_ram.sv
load_align.sv
mem_stage.sv
tb_mem_stage.sv

//--- tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage;
    import mem_pkg::*;

    logic               clk;
    logic               rst_n_i;
    logic               inst_valid_i;
    logic               inst_ready_o;
    logic [31:0]        inst_addr_i;
    logic [1:0]         inst_size_i;
    logic               inst_is_rep_i;
    logic               inst_dflag_i;
    logic [COUNT_W-1:0] inst_count_i;
    logic               wb_valid_i;
    logic [31:0]        wb_addr_i;
    logic [DATA_W-1:0]  wb_data_i;
    logic               res_valid_o;
    logic               res_ready_i;
    logic [DATA_W-1:0]  res_data_o;
    logic               res_last_o;

    // stimulus table, one row per instruction
    string        t_name  [16];
    logic [31:0]  t_addr  [16];
    logic [1:0]   t_size  [16];
    logic         t_rep   [16];
    logic         t_dflag [16];
    int           t_count [16];
    int           n_inst;

    logic [31:0]  model [RAM_WORDS];
    logic [31:0]  exp_data [$];
    logic         exp_last [$];
    string        exp_name [$];
    logic [31:0]  lfsr_state;
    int           timeout_limit;
    int           cycles;

    mem_stage mem_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = !clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    task automatic lfsr_take(input int nbits, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    task automatic add_inst(input string name, input logic [31:0] addr, input logic [1:0] size,
                            input logic rep, input logic dflag, input int count);
        t_name[n_inst]  = name;
        t_addr[n_inst]  = addr;
        t_size[n_inst]  = size;
        t_rep[n_inst]   = rep;
        t_dflag[n_inst] = dflag;
        t_count[n_inst] = count;
        n_inst++;
    endtask

    // expected loads of one instruction, taken from the memory model
    task automatic queue_expected(input int k);
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] lane;
        int          n;
        int          step;
        a = t_addr[k];
        n = t_rep[k] ? t_count[k] : 1;
        step = (t_size[k] == SIZE_BYTE) ? 1 : (t_size[k] == SIZE_WORD) ? 2 : 4;
        for (int j = 0; j < n; j++) begin
            w = model[a[9:2]];
            case (t_size[k])
                SIZE_BYTE: lane = (w >> (8 * a[1:0])) & 32'h0000_00ff;
                SIZE_WORD: lane = (w >> (16 * a[1])) & 32'h0000_ffff;
                default:   lane = w;
            endcase
            exp_data.push_back(lane);
            exp_last.push_back(j == n - 1);
            exp_name.push_back($sformatf("%s[%0d]", t_name[k], j));
            a = t_dflag[k] ? a - step : a + step;
        end
    endtask

    task automatic watch_results();
        logic [31:0] bits;
        forever begin
            @(posedge clk);
            if (res_valid_o && res_ready_i) begin
                if (exp_data.size() == 0) begin
                    $display("result %h arrived with no load outstanding", res_data_o);
                    $display("Test failed");
                    $fatal(1, "extra result");
                end else begin
                    check_value(exp_name[0], exp_data[0], res_data_o);
                    check_value({exp_name[0], " last"}, {31'd0, exp_last[0]},
                                {31'd0, res_last_o});
                    void'(exp_data.pop_front());
                    void'(exp_last.pop_front());
                    void'(exp_name.pop_front());
                end
            end
            lfsr_take(1, bits);
            res_ready_i <= bits[0];
        end
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_limit) begin
                $display("run timed out after %0d cycles", cycles);
                $display("Test failed");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        logic [31:0] w;
        int          total;
        rst_n_i       = 1'b0;
        inst_valid_i  = 1'b0;
        inst_addr_i   = '0;
        inst_size_i   = SIZE_BYTE;
        inst_is_rep_i = 1'b0;
        inst_dflag_i  = 1'b0;
        inst_count_i  = '0;
        wb_valid_i    = 1'b0;
        wb_addr_i     = '0;
        wb_data_i     = '0;
        res_ready_i   = 1'b0;
        lfsr_state    = 32'h6fbb;
        n_inst        = 0;

        add_inst("byte_off0", 32'h010, SIZE_BYTE, 1'b0, 1'b0, 0);
        add_inst("byte_off1", 32'h011, SIZE_BYTE, 1'b0, 1'b0, 0);
        add_inst("byte_off2", 32'h012, SIZE_BYTE, 1'b0, 1'b1, 0);
        add_inst("byte_off3", 32'h013, SIZE_BYTE, 1'b0, 1'b0, 7);
        add_inst("word_off0", 32'h020, SIZE_WORD, 1'b0, 1'b0, 0);
        add_inst("word_off2", 32'h022, SIZE_WORD, 1'b0, 1'b0, 0);
        add_inst("dword", 32'h030, SIZE_DWORD, 1'b0, 1'b0, 0);
        add_inst("rep_up_byte", 32'h041, SIZE_BYTE, 1'b1, 1'b0, 6);
        add_inst("rep_up_word", 32'h100, SIZE_WORD, 1'b1, 1'b0, 5);
        add_inst("rep_down_dword", 32'h008, SIZE_DWORD, 1'b1, 1'b1, 5);
        add_inst("rep_zero", 32'h200, SIZE_BYTE, 1'b1, 1'b0, 0);
        add_inst("after_zero", 32'h204, SIZE_DWORD, 1'b0, 1'b0, 0);
        add_inst("rep_up_wrap", 32'h3fa, SIZE_WORD, 1'b1, 1'b0, 4);
        add_inst("rep_down_byte", 32'h003, SIZE_BYTE, 1'b1, 1'b1, 8);
        add_inst("rep_zero_word", 32'h080, SIZE_WORD, 1'b1, 1'b0, 0);
        add_inst("rep_up_long", 32'h300, SIZE_DWORD, 1'b1, 1'b0, 12);

        total = 0;
        for (int k = 0; k < n_inst; k++) begin
            total += t_rep[k] ? t_count[k] : 1;
        end
        timeout_limit = 4 * total + 300;

        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        check_value("reset res_valid", 32'd0, {31'd0, res_valid_o});
        check_value("reset inst_ready", 32'd1, {31'd0, inst_ready_o});

        for (int i = 0; i < RAM_WORDS; i++) begin
            lfsr_take(32, w);
            model[i]   = w;
            wb_valid_i <= 1'b1;
            wb_addr_i  <= i << 2;
            wb_data_i  <= w;
            @(posedge clk);
        end
        wb_valid_i <= 1'b0;

        fork
            watch_results();
        join_none

        for (int k = 0; k < n_inst; k++) begin
            queue_expected(k);
            inst_valid_i  <= 1'b1;
            inst_addr_i   <= t_addr[k];
            inst_size_i   <= t_size[k];
            inst_is_rep_i <= t_rep[k];
            inst_dflag_i  <= t_dflag[k];
            inst_count_i  <= COUNT_W'(t_count[k]);
            @(posedge clk);
            while (!inst_ready_o) @(posedge clk);
        end
        inst_valid_i <= 1'b0;

        while (exp_data.size() != 0) @(posedge clk);
        // a few idle cycles so a stray result would still be caught
        repeat (20) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        inst_valid_i,
    output logic                        inst_ready_o,
    input  logic [31:0]                 inst_addr_i,
    input  logic [1:0]                  inst_size_i,
    input  logic                        inst_is_rep_i,
    input  logic                        inst_dflag_i,
    input  logic [mem_pkg::COUNT_W-1:0] inst_count_i,
    input  logic                        wb_valid_i,
    input  logic [31:0]                 wb_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  wb_data_i,
    output logic                        res_valid_o,
    input  logic                        res_ready_i,
    output logic [mem_pkg::DATA_W-1:0]  res_data_o,
    output logic                        res_last_o
);

    mem_req_if req_if ();
    mem_rsp_if rsp_if ();

    rep_sequencer rep_sequencer_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_ready_o  (inst_ready_o),
        .inst_addr_i   (inst_addr_i),
        .inst_size_i   (inst_size_i),
        .inst_is_rep_i (inst_is_rep_i),
        .inst_dflag_i  (inst_dflag_i),
        .inst_count_i  (inst_count_i),
        .req           (req_if.src)
    );

    dcache_ram dcache_ram_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wb_valid_i (wb_valid_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .req        (req_if.dst),
        .rsp        (rsp_if.src)
    );

    load_align load_align_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rsp         (rsp_if.dst),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_data_o  (res_data_o),
        .res_last_o  (res_last_o)
    );

endmodule

//--- load_align.sv
`timescale 1ns/10ps

module load_align (
    input  logic                       clk,
    input  logic                       rst_n_i,
    mem_rsp_if.dst                     rsp,
    output logic                       res_valid_o,
    input  logic                       res_ready_i,
    output logic [mem_pkg::DATA_W-1:0] res_data_o,
    output logic                       res_last_o
);
    import mem_pkg::*;

    logic [DATA_W-1:0] lane_data;
    logic [DATA_W-1:0] data_q [2];
    logic              last_q [2];
    logic              wr_ptr_q;
    logic              rd_ptr_q;
    logic [1:0]        count_q;
    logic              push;
    logic              pop;

    // pick the addressed lane and zero-extend it
    always_comb begin
        case (rsp.size)
            SIZE_BYTE:  lane_data = {24'd0, rsp.word.bytes[rsp.offset]};
            SIZE_WORD:  lane_data = {16'd0, rsp.word.halves[rsp.offset[1]]};
            default:    lane_data = rsp.word.dword;
        endcase
    end

    assign rsp.ready = (count_q != 2'd2);
    assign push      = rsp.valid && rsp.ready;
    assign pop       = res_valid_o && res_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_q[wr_ptr_q] <= lane_data;
            last_q[wr_ptr_q] <= rsp.last;
        end
    end

    // head of the queue
    assign res_valid_o = (count_q != 2'd0);
    assign res_data_o  = data_q[rd_ptr_q];
    assign res_last_o  = last_q[rd_ptr_q];

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (push && !pop) |=> (count_q <= 2'd2));

endmodule

//--- dcache_ram.sv
`timescale 1ns/10ps

module dcache_ram (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       wb_valid_i,
    input  logic [31:0]                wb_addr_i,
    input  logic [mem_pkg::DATA_W-1:0] wb_data_i,
    mem_req_if.dst                     req,
    mem_rsp_if.src                     rsp
);
    import mem_pkg::*;

    mem_word_u            mem [RAM_WORDS];

    logic [RAM_IDX_W-1:0] rd_idx;
    logic [RAM_IDX_W-1:0] wb_idx;
    logic                 req_fire;

    logic                 rsp_valid_q;
    mem_word_u            word_q;
    logic [1:0]           offset_q;
    logic [1:0]           size_q;
    logic                 last_q;

    assign rd_idx = req.addr[RAM_IDX_W+1:2];
    assign wb_idx = wb_addr_i[RAM_IDX_W+1:2];

    // accept a read when the response slot is free or drains this cycle
    assign req.ready = !rsp_valid_q || rsp.ready;
    assign req_fire  = req.valid && req.ready;

    // whole-dword writeback, a same-cycle read still sees the old word
    always_ff @(posedge clk) begin
        if (wb_valid_i) begin
            mem[wb_idx].dword <= wb_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp.ready) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            word_q   <= mem[rd_idx];
            offset_q <= req.addr[1:0];
            size_q   <= req.size;
            last_q   <= req.last;
        end
    end

    assign rsp.valid  = rsp_valid_q;
    assign rsp.word   = word_q;
    assign rsp.offset = offset_q;
    assign rsp.size   = size_q;
    assign rsp.last   = last_q;

    // a stalled response stays up with the same payload
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (rsp.valid && !rsp.ready) |=> (rsp.valid && $stable(rsp.word) && $stable(rsp.last)));

endmodule

//--- rep_sequencer.sv
`timescale 1ns/10ps

module rep_sequencer (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      inst_valid_i,
    output logic                      inst_ready_o,
    input  logic [31:0]               inst_addr_i,
    input  logic [1:0]                inst_size_i,
    input  logic                      inst_is_rep_i,
    input  logic                      inst_dflag_i,
    input  logic [mem_pkg::COUNT_W-1:0] inst_count_i,
    mem_req_if.src                    req
);
    import mem_pkg::*;

    logic               busy_q;
    logic [COUNT_W-1:0] cnt_q;
    logic [31:0]        addr_q;
    logic [1:0]         size_q;
    logic               dflag_q;
    logic               inst_accept;
    logic               req_fire;
    logic [1:0]         align_mask;

    // address increment per load, same table as the x86 string ops
    function automatic logic [31:0] step_of(input logic [1:0] size, input logic dflag);
        logic [31:0] mag;
        case (size)
            SIZE_BYTE:  mag = 32'd1;
            SIZE_WORD:  mag = 32'd2;
            SIZE_DWORD: mag = 32'd4;
            default:    mag = 32'd0;
        endcase
        return dflag ? -mag : mag;
    endfunction

    assign inst_ready_o = !busy_q;
    assign inst_accept  = inst_valid_i && inst_ready_o;
    assign req_fire     = req.valid && req.ready;

    assign req.valid = busy_q;
    assign req.addr  = addr_q;
    assign req.size  = size_q;
    assign req.last  = (cnt_q == COUNT_W'(1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (inst_accept) begin
            // rep with a zero count never leaves idle
            busy_q <= !(inst_is_rep_i && (inst_count_i == '0));
            cnt_q  <= inst_is_rep_i ? inst_count_i : COUNT_W'(1);
        end else if (req_fire) begin
            if (req.last) begin
                busy_q <= 1'b0;
            end
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_accept) begin
            addr_q  <= inst_addr_i;
            size_q  <= inst_size_i;
            dflag_q <= inst_dflag_i;
        end else if (req_fire) begin
            addr_q <= addr_q + step_of(size_q, dflag_q);
        end
    end

    always_comb begin
        case (inst_size_i)
            SIZE_WORD:  align_mask = 2'b01;
            SIZE_DWORD: align_mask = 2'b11;
            default:    align_mask = 2'b00;
        endcase
    end

    // every request the memory sees carries a legal size
    assert property (@(posedge clk) disable iff (!rst_n_i)
        req.valid |-> (req.size != 2'd3));

    assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_accept |-> ((inst_addr_i[1:0] & align_mask) == 2'b00));

endmodule

//--- mem_rsp_if.sv
`timescale 1ns/10ps

interface mem_rsp_if;
    import mem_pkg::*;

    logic       valid;
    logic       ready;
    mem_word_u  word;
    logic [1:0] offset;
    logic [1:0] size;
    logic       last;

    modport src (
        output valid,
        output word,
        output offset,
        output size,
        output last,
        input  ready
    );

    modport dst (
        input  valid,
        input  word,
        input  offset,
        input  size,
        input  last,
        output ready
    );

endinterface

//--- mem_req_if.sv
`timescale 1ns/10ps

interface mem_req_if;

    logic        valid;
    logic        ready;
    logic [31:0] addr;
    logic [1:0]  size;
    logic        last;

    // addr, size and last hold while valid is up and ready is low
    modport src (
        output valid,
        output addr,
        output size,
        output last,
        input  ready
    );

    modport dst (
        input  valid,
        input  addr,
        input  size,
        input  last,
        output ready
    );

endinterface

//--- mem_pkg.sv
package mem_pkg;

    // operand size codes, code 3 is illegal
    localparam logic [1:0] SIZE_BYTE  = 2'd0;
    localparam logic [1:0] SIZE_WORD  = 2'd1;
    localparam logic [1:0] SIZE_DWORD = 2'd2;

    localparam int DATA_W = 32;

    // word memory geometry, the index is taken from address bits 9..2
    localparam int RAM_WORDS = 256;
    localparam int RAM_IDX_W = 8;

    // rep iteration counter
    localparam int COUNT_W = 16;

    // one read word, seen as a dword or as its byte and halfword lanes
    typedef union packed {
        logic [DATA_W-1:0]   dword;
        logic [3:0][7:0]     bytes;
        logic [1:0][15:0]    halves;
    } mem_word_u;

endpackage
